// ==== rtl/txq_pkg.sv ====
// Shared constants and types for the eight-antenna transmit data queue.
// Each module that needs these imports the package in its header.
// Group 0 carries the even antennas and group 1 the odd antennas.

package txq_pkg;

    // --------------------
    // Sizes
    // --------------------
    localparam int ANT_NUM    = 8;
    localparam int GRP_NUM    = 2;
    localparam int LANE_NUM   = 4;
    localparam int SAMPLE_W   = 32;
    localparam int AGC_W      = 8;

    // Framing of the output stream
    localparam int RE_PER_RB  = 12;
    localparam int RB_PER_PKT = 4;
    localparam int PRB_COUNT  = 132;
    localparam int PRB_W      = 9;

    // --------------------
    // Data types
    // --------------------
    // One input beat, sample n belongs to antenna n
    typedef logic [ANT_NUM-1:0][SAMPLE_W-1:0] txq_ant_beat_t;

    // Per-antenna gains of one beat
    typedef logic [ANT_NUM-1:0][AGC_W-1:0] txq_agc_t;

    // Four gains of one antenna group
    typedef logic [LANE_NUM-1:0][AGC_W-1:0] txq_gain_t;

    // Four samples of one group, lane k is antenna 2k + group
    typedef logic [LANE_NUM-1:0][SAMPLE_W-1:0] txq_group_word_t;

    // Block metadata, 52 bits, gain word on top
    typedef struct packed {
        txq_gain_t  gain;
        logic [3:0] rbg_idx;
        logic [3:0] pkg_type;
        logic       cell_idx;
        logic [6:0] slot_idx;
        logic [3:0] symb_idx;
    } txq_meta_t;

    // Lane tag on the output
    typedef struct packed {
        logic [3:0] grp;
        logic [3:0] ant;
    } txq_pkg_info_t;

endpackage

// ==== rtl/txq_write_ctrl.sv ====
// Write side of the queue. Splits each accepted beat into the even and odd
// antenna words, addresses them into the current slot of the two group RAMs
// and pulses o_commit once a whole block has been written.
// Also keeps the metadata of each slot and hands it to the read side.

`timescale 1ns/1ps

module txq_write_ctrl
    import txq_pkg::*;
#(
    parameter int BLOCK_LEN = 48,
    parameter int ADDR_W    = 7
) (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_valid,
    input  txq_ant_beat_t      i_ant_data,
    input  txq_agc_t           i_agc,
    input  txq_meta_t          i_meta_in,
    input  logic               i_rd_slot,
    input  logic               i_rd_group,
    output logic               o_wr_en,
    output logic [ADDR_W-1:0]  o_wr_addr,
    output txq_group_word_t    o_wr_word0,
    output txq_group_word_t    o_wr_word1,
    output logic               o_commit,
    output txq_meta_t          o_rd_meta
);

    logic [ADDR_W-1:0] beat_cnt;
    logic [ADDR_W-1:0] slot_base;
    logic              wr_slot;
    logic              wr_last;
    txq_gain_t         gain_even;
    txq_gain_t         gain_odd;

    // Record per slot with the group 1 gains kept beside it
    txq_meta_t         slot_meta  [2];
    txq_gain_t         slot_gain1 [2];

    assign slot_base = wr_slot ? ADDR_W'(BLOCK_LEN) : '0;

    always_comb begin
        for (int k = 0; k < LANE_NUM; k++) begin
            gain_even[k] = i_agc[2*k];
            gain_odd[k]  = i_agc[2*k+1];
        end
    end

    // --------------------
    // Beat counter and commit
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            beat_cnt <= '0;
            wr_slot  <= 1'b0;
            o_wr_en  <= 1'b0;
            wr_last  <= 1'b0;
            o_commit <= 1'b0;
        end else begin
            o_wr_en  <= i_valid;
            wr_last  <= i_valid && (beat_cnt == ADDR_W'(BLOCK_LEN - 1));
            o_commit <= o_wr_en && wr_last;
            if (i_valid) begin
                if (beat_cnt == ADDR_W'(BLOCK_LEN - 1)) begin
                    beat_cnt <= '0;
                    wr_slot  <= ~wr_slot;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // Even antennas to group 0, odd to group 1
    always_ff @(posedge i_clk) begin
        o_wr_addr <= slot_base + beat_cnt;
        for (int k = 0; k < LANE_NUM; k++) begin
            o_wr_word0[k] <= i_ant_data[2*k];
            o_wr_word1[k] <= i_ant_data[2*k+1];
        end
    end

    // Metadata taken on the first beat of a block
    always_ff @(posedge i_clk) begin
        if (i_valid && (beat_cnt == '0)) begin
            slot_meta[wr_slot]      <= i_meta_in;
            slot_meta[wr_slot].gain <= gain_even;
            slot_gain1[wr_slot]     <= gain_odd;
        end
    end

    always_comb begin
        o_rd_meta = slot_meta[i_rd_slot];
        if (i_rd_group) begin
            o_rd_meta.gain = slot_gain1[i_rd_slot];
        end
    end

endmodule

// ==== rtl/txq_block_ram.sv ====
// Two-slot block memory for one antenna group.
// Simple dual port: one write port, one read port with registered output,
// so read data shows up one cycle after the read address.
// Slot 0 covers addresses below BLOCK_LEN, slot 1 the next BLOCK_LEN words.

`timescale 1ns/1ps

module txq_block_ram
    import txq_pkg::*;
#(
    parameter int BLOCK_LEN = 48,
    parameter int ADDR_W    = 7
) (
    input  logic               i_clk,
    input  logic               i_wr_en,
    input  logic [ADDR_W-1:0]  i_wr_addr,
    input  txq_group_word_t    i_wr_word,
    input  logic [ADDR_W-1:0]  i_rd_addr,
    output txq_group_word_t    o_rd_word
);

    localparam int DEPTH = 2 * BLOCK_LEN;

    txq_group_word_t mem [DEPTH];

    // Write port
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_word;
        end
    end

    // Read port, always enabled
    always_ff @(posedge i_clk) begin
        o_rd_word <= mem[i_rd_addr];
    end

endmodule

// ==== rtl/txq_read_sched.sv ====
// Read scheduler of the queue.
// Tracks how many of the two slots hold unread data and derives o_ready.
// A committed block is replayed as BLOCK_LEN addresses of group 0 followed
// by BLOCK_LEN addresses of group 1, then its slot is released.
// Valid, slot and group are delayed to line up with the RAM read data.

`timescale 1ns/1ps

module txq_read_sched #(
    parameter int BLOCK_LEN = 48,
    parameter int ADDR_W    = 7
) (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_commit,
    input  logic               i_valid,
    output logic [ADDR_W-1:0]  o_rd_addr,
    output logic               o_rd_slot,
    output logic               o_rd_group,
    output logic               o_data_vld,
    output logic               o_ready
);

    logic [ADDR_W-1:0] in_cnt;
    logic [ADDR_W-1:0] rd_cnt;
    logic [ADDR_W-1:0] rd_base;
    logic [1:0]        occ;
    logic [1:0]        pend;
    logic              rd_active;
    logic              rd_group;
    logic              rd_slot;
    logic              blk_start;
    logic              rd_start;
    logic              rd_last;
    logic              rd_done;

    // A slot is taken on the first beat of the block written into it
    assign blk_start = i_valid && (in_cnt == '0);
    assign rd_start  = !rd_active && (pend != 2'd0);
    assign rd_last   = rd_active && (rd_cnt == ADDR_W'(BLOCK_LEN - 1));
    assign rd_done   = rd_last && rd_group;
    assign rd_base   = rd_slot ? ADDR_W'(BLOCK_LEN) : '0;
    assign o_rd_addr = rd_base + rd_cnt;

    // Only block a new block, never the rest of one in progress
    assign o_ready = !((occ == 2'd2) && (in_cnt == '0));

    // --------------------
    // Occupancy
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            in_cnt <= '0;
            occ    <= '0;
            pend   <= '0;
        end else begin
            if (i_valid) begin
                in_cnt <= (in_cnt == ADDR_W'(BLOCK_LEN - 1)) ? '0 : in_cnt + 1'b1;
            end
            occ  <= occ + 2'(blk_start) - 2'(rd_done);
            pend <= pend + 2'(i_commit) - 2'(rd_start);
        end
    end

    // --------------------
    // Address walk
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rd_active <= 1'b0;
            rd_group  <= 1'b0;
            rd_slot   <= 1'b0;
            rd_cnt    <= '0;
        end else if (rd_start) begin
            rd_active <= 1'b1;
            rd_group  <= 1'b0;
            rd_cnt    <= '0;
        end else if (rd_last) begin
            rd_cnt <= '0;
            if (rd_group) begin
                rd_active <= 1'b0;
                rd_slot   <= ~rd_slot;
            end else begin
                rd_group <= 1'b1;
            end
        end else if (rd_active) begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

    // Match the RAM read latency
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_data_vld <= 1'b0;
        end else begin
            o_data_vld <= rd_active;
        end
        o_rd_group <= rd_group;
        o_rd_slot  <= rd_slot;
    end

    a_occ_max: assert property (@(posedge i_clk) disable iff (i_reset)
        occ <= 2'd2);

    // A commit always closes a block that already holds a slot
    a_commit_occ: assert property (@(posedge i_clk) disable iff (i_reset)
        i_commit |-> (occ != 2'd0));

    // Source must hold off while the queue is full
    a_no_beat_when_full: assert property (@(posedge i_clk) disable iff (i_reset)
        !o_ready |-> !i_valid);

endmodule

// ==== rtl/txq_frame_gen.sv ====
// Output framing of the queue.
// Counts valid beats into resource blocks of twelve, marks start and end,
// keeps the running resource-block index and tags each lane with its
// group and antenna number. All outputs are registered once.

`timescale 1ns/1ps

module txq_frame_gen
    import txq_pkg::*;
(
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_data_vld,
    input  logic                           i_group,
    input  logic [3:0]                     i_lane_idx,
    input  txq_group_word_t                i_rd_word,
    input  txq_meta_t                      i_rd_meta,
    output txq_group_word_t                o_tx_data,
    output logic                           o_tx_vld,
    output logic                           o_tx_sop,
    output logic                           o_tx_eop,
    output logic [PRB_W-1:0]               o_prb_idx,
    output txq_pkg_info_t [LANE_NUM-1:0]   o_pkg_info,
    output txq_meta_t                      o_meta
);

    localparam int RE_W = $clog2(RE_PER_RB);
    localparam int RB_W = $clog2(RB_PER_PKT);

    logic [RE_W-1:0]  re_cnt;
    logic [RB_W-1:0]  rb_cnt;
    logic [PRB_W-1:0] prb_cnt;
    logic [3:0]       ant_base;
    logic             re_sop;
    logic             re_eop;

    assign re_eop   = i_data_vld && (re_cnt == RE_W'(RE_PER_RB - 1));
    assign re_sop   = i_data_vld && (re_cnt == '0) && (rb_cnt == '0);
    // Second set of eight antennas for lane index 1
    assign ant_base = i_lane_idx << 3;

    // --------------------
    // RE, RB and PRB counters
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            re_cnt  <= '0;
            rb_cnt  <= '0;
            prb_cnt <= '0;
        end else if (i_data_vld) begin
            re_cnt <= re_eop ? '0 : re_cnt + 1'b1;
            if (re_eop) begin
                rb_cnt  <= (rb_cnt == RB_W'(RB_PER_PKT - 1)) ? '0 : rb_cnt + 1'b1;
                prb_cnt <= (prb_cnt == PRB_W'(PRB_COUNT - 1)) ? '0 : prb_cnt + 1'b1;
            end
        end
    end

    // Index shown on a beat is the one before its end marker advances it
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_tx_vld  <= 1'b0;
            o_tx_sop  <= 1'b0;
            o_tx_eop  <= 1'b0;
            o_prb_idx <= '0;
        end else begin
            o_tx_vld  <= i_data_vld;
            o_tx_sop  <= re_sop;
            o_tx_eop  <= re_eop;
            o_prb_idx <= prb_cnt;
        end
    end

    always_ff @(posedge i_clk) begin
        o_tx_data <= i_rd_word;
        o_meta    <= i_rd_meta;
        for (int k = 0; k < LANE_NUM; k++) begin
            o_pkg_info[k].grp <= {3'b000, i_group};
            o_pkg_info[k].ant <= ant_base + 4'(2 * k) + {3'b000, i_group};
        end
    end

endmodule

// ==== rtl/txq_top.sv ====
// Top level of the transmit data queue.
// Beats of eight antennas go in under a valid/ready handshake, committed
// blocks come out as four lanes, group 0 first and then group 1.
// BLOCK_LEN and ADDR_W are set here and passed to the submodules.

`timescale 1ns/1ps

module txq_top
    import txq_pkg::*;
#(
    parameter int BLOCK_LEN = 48,
    parameter int ADDR_W    = 7
) (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_valid,
    input  txq_ant_beat_t                  i_ant_data,
    input  txq_agc_t                       i_agc,
    input  txq_meta_t                      i_meta_in,
    input  logic [3:0]                     i_lane_idx,
    output logic                           o_ready,
    output txq_group_word_t                o_tx_data,
    output logic                           o_tx_vld,
    output logic                           o_tx_sop,
    output logic                           o_tx_eop,
    output logic [PRB_W-1:0]               o_prb_idx,
    output txq_pkg_info_t [LANE_NUM-1:0]   o_pkg_info,
    output txq_meta_t                      o_meta
);

    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic              commit;
    logic [ADDR_W-1:0] rd_addr;
    logic              rd_slot;
    logic              rd_group;
    logic              data_vld;
    txq_meta_t         rd_meta;
    txq_group_word_t   wr_word [GRP_NUM];
    txq_group_word_t   rd_word [GRP_NUM];

    txq_write_ctrl #(
        .BLOCK_LEN  (BLOCK_LEN),
        .ADDR_W     (ADDR_W)
    ) u_write_ctrl (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_valid    (i_valid),
        .i_ant_data (i_ant_data),
        .i_agc      (i_agc),
        .i_meta_in  (i_meta_in),
        .i_rd_slot  (rd_slot),
        .i_rd_group (rd_group),
        .o_wr_en    (wr_en),
        .o_wr_addr  (wr_addr),
        .o_wr_word0 (wr_word[0]),
        .o_wr_word1 (wr_word[1]),
        .o_commit   (commit),
        .o_rd_meta  (rd_meta)
    );

    // One memory per antenna group, shared addresses
    for (genvar g = 0; g < GRP_NUM; g++) begin : g_ram
        txq_block_ram #(
            .BLOCK_LEN (BLOCK_LEN),
            .ADDR_W    (ADDR_W)
        ) u_ram (
            .i_clk     (i_clk),
            .i_wr_en   (wr_en),
            .i_wr_addr (wr_addr),
            .i_wr_word (wr_word[g]),
            .i_rd_addr (rd_addr),
            .o_rd_word (rd_word[g])
        );
    end

    txq_read_sched #(
        .BLOCK_LEN  (BLOCK_LEN),
        .ADDR_W     (ADDR_W)
    ) u_read_sched (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_commit   (commit),
        .i_valid    (i_valid),
        .o_rd_addr  (rd_addr),
        .o_rd_slot  (rd_slot),
        .o_rd_group (rd_group),
        .o_data_vld (data_vld),
        .o_ready    (o_ready)
    );

    txq_frame_gen u_frame_gen (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_data_vld (data_vld),
        .i_group    (rd_group),
        .i_lane_idx (i_lane_idx),
        .i_rd_word  (rd_word[rd_group]),
        .i_rd_meta  (rd_meta),
        .o_tx_data  (o_tx_data),
        .o_tx_vld   (o_tx_vld),
        .o_tx_sop   (o_tx_sop),
        .o_tx_eop   (o_tx_eop),
        .o_prb_idx  (o_prb_idx),
        .o_pkg_info (o_pkg_info),
        .o_meta     (o_meta)
    );

endmodule

// ==== include/tb_txq_tasks.svh ====
// Directed tests of tb_txq and the helpers that build and send blocks.
// Included inside the tb_txq module, so the tasks use the DUT signals and
// the expected-beat queues of the testbench directly.

`ifndef TB_TXQ_TASKS_SVH
`define TB_TXQ_TASKS_SVH

// Builds one random block, queues its expected output and sends it
task automatic send_block(input logic quiet_out);
    txq_ant_beat_t   beats [BLOCK_LEN];
    txq_agc_t        agcs  [BLOCK_LEN];
    txq_meta_t       meta;
    txq_meta_t       em;
    txq_group_word_t w;
    int              waited;
    meta          = '0;
    meta.rbg_idx  = 4'($random(seed));
    meta.pkg_type = 4'($random(seed));
    meta.cell_idx = 1'($random(seed));
    meta.slot_idx = 7'($random(seed));
    meta.symb_idx = 4'($random(seed));
    for (int b = 0; b < BLOCK_LEN; b++) begin
        for (int n = 0; n < ANT_NUM; n++) begin
            beats[b][n] = $random(seed);
            agcs[b][n]  = 8'($random(seed));
        end
    end
    // Group 0 is all even antennas, then group 1 the odd ones
    for (int g = 0; g < GRP_NUM; g++) begin
        em = meta;
        for (int k = 0; k < LANE_NUM; k++) em.gain[k] = agcs[0][2*k+g];
        for (int b = 0; b < BLOCK_LEN; b++) begin
            for (int k = 0; k < LANE_NUM; k++) w[k] = beats[b][2*k+g];
            exp_data.push_back(w);
            exp_meta.push_back(em);
            exp_grp.push_back(1'(g));
        end
    end
    for (int b = 0; b < BLOCK_LEN; b++) begin
        @(negedge i_clk);
        waited = 0;
        while (!o_ready && waited < READY_LIMIT) begin
            i_valid = 1'b0;
            @(negedge i_clk);
            waited++;
        end
        if (!o_ready) begin
            i_valid = 1'b0;
            note_failure("o_ready stayed low, the block could not be sent");
            return;
        end
        if (quiet_out && o_tx_vld) log_error("output started before the block was complete");
        i_valid    = 1'b1;
        i_ant_data = beats[b];
        i_agc      = agcs[b];
        // Only the first beat's record counts
        i_meta_in  = '0;
        if (b == 0) i_meta_in = meta;
        else i_meta_in.slot_idx = 7'(b);
    end
endtask

task automatic idle_input();
    @(negedge i_clk);
    i_valid = 1'b0;
endtask

task automatic wait_drain();
    int waited = 0;
    while (exp_data.size() != 0 && waited < DRAIN_LIMIT) begin
        @(negedge i_clk);
        waited++;
    end
    if (exp_data.size() != 0) begin
        note_failure($sformatf("%0d expected output beats never came out", exp_data.size()));
        exp_data.delete();
        exp_meta.delete();
        exp_grp.delete();
    end
    repeat (4) @(negedge i_clk);
endtask

// --------------------
// Directed tests
// --------------------
task automatic test_reset_state();
    repeat (8) begin
        @(negedge i_clk);
        if (o_ready !== 1'b1) log_error("o_ready not high after reset");
        if (o_tx_vld !== 1'b0 || o_tx_sop !== 1'b0 || o_tx_eop !== 1'b0) begin
            log_error("output strobes not low after reset");
        end
        if (o_prb_idx !== '0) log_error($sformatf("prb index %0d after reset", o_prb_idx));
    end
endtask

task automatic test_group_order();
    send_block(1'b1);
    idle_input();
    wait_drain();
endtask

// Tags for the second set of eight antennas, then back to the first
task automatic test_lane_tags();
    i_lane_idx = 4'd1;
    send_block(1'b0);
    idle_input();
    wait_drain();
    i_lane_idx = 4'd0;
    send_block(1'b0);
    idle_input();
    wait_drain();
endtask

task automatic test_back_pressure();
    int falls0;
    int rises0;
    falls0 = ready_falls;
    rises0 = ready_rises;
    repeat (BP_BLOCKS) send_block(1'b0);
    idle_input();
    wait_drain();
    if (ready_falls == falls0) note_failure("o_ready never fell with two blocks outstanding");
    if (ready_rises == rises0) note_failure("o_ready never rose again while draining");
    if (o_ready !== 1'b1) log_error("o_ready low after the queue drained");
endtask

task automatic test_prb_wrap();
    repeat (WRAP_BLOCKS) send_block(1'b0);
    idle_input();
    wait_drain();
    if (!wrap_seen) note_failure("resource-block index never wrapped back to 0");
endtask

`endif

// ==== bench/tb_txq.sv ====
// Testbench for the transmit data queue.
// Sends blocks of eight-antenna beats into txq_top and keeps a queue of the
// output beats each block should produce. A monitor compares every o_tx_vld
// beat with that queue. The directed tests are in the included task file.

`timescale 1ns/1ps

module tb_txq
    import txq_pkg::*;
();

    localparam int BLOCK_LEN    = 48;
    localparam int ADDR_W       = 7;
    localparam int BP_BLOCKS    = 6;
    localparam int WRAP_BLOCKS  = 12;
    localparam int TOTAL_BLOCKS = 3 + BP_BLOCKS + WRAP_BLOCKS;
    localparam int WATCHDOG_CYC = TOTAL_BLOCKS * BLOCK_LEN * 20;
    localparam int READY_LIMIT  = 4 * BLOCK_LEN;
    localparam int DRAIN_LIMIT  = 8 * BLOCK_LEN;
    localparam int PKT_BEATS    = RE_PER_RB * RB_PER_PKT;

    logic                         i_clk;
    logic                         i_reset;
    logic                         i_valid;
    txq_ant_beat_t                i_ant_data;
    txq_agc_t                     i_agc;
    txq_meta_t                    i_meta_in;
    logic [3:0]                   i_lane_idx;
    logic                         o_ready;
    txq_group_word_t              o_tx_data;
    logic                         o_tx_vld;
    logic                         o_tx_sop;
    logic                         o_tx_eop;
    logic [PRB_W-1:0]             o_prb_idx;
    txq_pkg_info_t [LANE_NUM-1:0] o_pkg_info;
    txq_meta_t                    o_meta;

    // Expected output beats in the order they must appear
    txq_group_word_t exp_data [$];
    txq_meta_t       exp_meta [$];
    logic            exp_grp  [$];

    integer seed        = 32'hfbfeaa00;
    int     n_errors    = 0;
    int     n_checked   = 0;
    int     out_cnt     = 0;
    int     ready_falls = 0;
    int     ready_rises = 0;
    logic   prev_ready  = 1'b1;
    logic   wrap_seen   = 1'b0;

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    txq_top #(
        .BLOCK_LEN  (BLOCK_LEN),
        .ADDR_W     (ADDR_W)
    ) uut (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_valid    (i_valid),
        .i_ant_data (i_ant_data),
        .i_agc      (i_agc),
        .i_meta_in  (i_meta_in),
        .i_lane_idx (i_lane_idx),
        .o_ready    (o_ready),
        .o_tx_data  (o_tx_data),
        .o_tx_vld   (o_tx_vld),
        .o_tx_sop   (o_tx_sop),
        .o_tx_eop   (o_tx_eop),
        .o_prb_idx  (o_prb_idx),
        .o_pkg_info (o_pkg_info),
        .o_meta     (o_meta)
    );

    task automatic log_error(input string msg);
        n_errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic note_failure(input string msg);
        n_errors++;
        $display("failure at %0t: %s", $time, msg);
    endtask

    // --------------------
    // Output monitor
    // --------------------
    always @(negedge i_clk) begin : output_monitor
        txq_group_word_t ed;
        txq_meta_t       em;
        logic            eg;
        logic [3:0]      ant;
        if (!i_reset) begin
            if (o_ready && !prev_ready) ready_rises++;
            if (!o_ready && prev_ready) ready_falls++;
            prev_ready = o_ready;
            if (o_tx_vld) begin
                if (exp_data.size() == 0) begin
                    note_failure("output beat seen with no block outstanding");
                end else begin
                    ed = exp_data.pop_front();
                    em = exp_meta.pop_front();
                    eg = exp_grp.pop_front();
                    n_checked++;
                    if (o_tx_data !== ed) begin
                        log_error($sformatf("beat %0d data %h, expected %h",
                                            out_cnt, o_tx_data, ed));
                    end
                    if (o_meta !== em) begin
                        log_error($sformatf("beat %0d meta %h, expected %h",
                                            out_cnt, o_meta, em));
                    end
                    for (int k = 0; k < LANE_NUM; k++) begin
                        // Antenna number is 8 * lane index + 2 * lane + group
                        ant = 4'(8 * i_lane_idx + 2 * k + eg);
                        if (o_pkg_info[k] !== {3'b000, eg, ant}) begin
                            log_error($sformatf("beat %0d lane %0d tag %h, expected %h",
                                                out_cnt, k, o_pkg_info[k], {3'b000, eg, ant}));
                        end
                    end
                end
                if (o_tx_sop !== (out_cnt % PKT_BEATS == 0)) begin
                    log_error($sformatf("beat %0d sop is %b", out_cnt, o_tx_sop));
                end
                if (o_tx_eop !== (out_cnt % RE_PER_RB == RE_PER_RB - 1)) begin
                    log_error($sformatf("beat %0d eop is %b", out_cnt, o_tx_eop));
                end
                if (o_prb_idx !== PRB_W'((out_cnt / RE_PER_RB) % PRB_COUNT)) begin
                    log_error($sformatf("beat %0d prb index %0d, expected %0d", out_cnt,
                                        o_prb_idx, (out_cnt / RE_PER_RB) % PRB_COUNT));
                end
                if (o_prb_idx == '0 && out_cnt >= RE_PER_RB * PRB_COUNT) wrap_seen = 1'b1;
                out_cnt++;
            end else if (o_tx_sop || o_tx_eop) begin
                log_error("sop or eop high without o_tx_vld");
            end
        end
    end

    `include "tb_txq_tasks.svh"

    initial begin
        repeat (WATCHDOG_CYC) @(posedge i_clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYC);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        i_reset    = 1'b1;
        i_valid    = 1'b0;
        i_ant_data = '0;
        i_agc      = '0;
        i_meta_in  = '0;
        i_lane_idx = 4'd0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        test_reset_state();
        test_group_order();
        test_lane_tags();
        test_back_pressure();
        test_prb_wrap();
        $display("checked %0d output beats, %0d errors", n_checked, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
rtl/txq_pkg.sv
rtl/txq_write_ctrl.sv
rtl/txq_block_ram.sv
rtl/txq_read_sched.sv
rtl/txq_frame_gen.sv
rtl/txq_top.sv
bench/tb_txq.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -Wno-fatal \
    --top-module tb_txq -f filelist.f -o tb_txq_sim

if ! ./obj_dir/tb_txq_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulator exited with an error"
    exit 1
fi
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0
